/* compile.f */
hdl/alert_pkg.sv
hdl/alert_diff_decode.sv
hdl/alert_sender.sv
hdl/alert_receiver.sv
hdl/ping_timer.sv
hdl/alert_channel.sv
bench/alert_channel_asserts.sv
bench/alert_channel_tb.sv

/* Makefile */
# sources come straight from the file list so the binary tracks every edit
SRCS := $(shell cat compile.f)

obj_dir/Valert_channel_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module alert_channel_tb -f compile.f

.PHONY: run clean

# the simulator exits with a failing status on any $fatal or assertion error
run: obj_dir/Valert_channel_tb
	./obj_dir/Valert_channel_tb

clean:
	rm -rf obj_dir

/* bench/alert_channel_tb.sv */
`timescale 1ns/1ps

module alert_channel_tb import alert_pkg::*; ();

  // kinds of rows in the stimulus table
  typedef enum logic [1:0] {OpInit, OpAlert, OpPing, OpTimeout} op_e;

  // each row runs one operation and names the pulses it must produce,
  // an expected alert count below zero means the count is not checked
  typedef struct packed {
    op_e op;
    int  count;
    int  exp_alert;
    int  fail_min;
    int  fail_max;
    int  exp_integ;
  } row_t;

  localparam int NUM_ROWS       = 7;
  localparam int ALERT_LATENCY  = 2;
  // ready comes back once ack has risen, alert has fallen and both pauses are over
  localparam int READY_RETURN   = ALERT_LATENCY + 2 + PAUSE_CYCLES;
  localparam int READY_TIMEOUT  = 64;
  localparam int IDLE_TIMEOUT   = 256;
  localparam int IDLE_STABLE    = 8;
  localparam int TIMEOUT_WINDOW = 200;
  // several times the longest ping round trip, yet short enough that a
  // missing answer shows up as a failure within one ping row
  localparam int GOOD_TIMEOUT   = 32;

  logic                 clk_i;
  logic                 rst_b;
  logic                 alert_valid_i;
  logic                 init_trig_i;
  logic                 ping_en_i;
  logic [TIMEOUT_W-1:0] ping_timeout_i;
  logic                 alert_ready_o;
  logic                 alert_o;
  logic                 integ_fail_o;
  logic                 ping_fail_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] lcg_state;
  int          alert_cnt;
  int          fail_cnt;
  int          integ_cnt;

  alert_channel i_alert_channel (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .alert_valid_i  (alert_valid_i),
    .init_trig_i    (init_trig_i),
    .ping_en_i      (ping_en_i),
    .ping_timeout_i (ping_timeout_i),
    .alert_ready_o  (alert_ready_o),
    .alert_o        (alert_o),
    .integ_fail_o   (integ_fail_o),
    .ping_fail_o    (ping_fail_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // pulse counters sample the outputs just before each edge
  always @(posedge clk_i) begin
    if (!rst_b) begin
      alert_cnt <= 0;
      fail_cnt  <= 0;
      integ_cnt <= 0;
    end else begin
      if (alert_o) begin
        alert_cnt <= alert_cnt + 1;
      end
      if (ping_fail_o) begin
        fail_cnt <= fail_cnt + 1;
      end
      if (integ_fail_o) begin
        integ_cnt <= integ_cnt + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks and helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_pulse(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected %h got %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_count(input string name, input int lo, input int hi, input int actual);
    if (actual < lo || actual > hi) begin
      if (lo == hi) begin
        $display("Mismatch %s expected %0h got %0h", name, lo, actual);
      end else begin
        $display("Mismatch %s expected %0h to %0h got %0h", name, lo, hi, actual);
      end
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Test failed");
    $fatal(1, "wait limit reached");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // the channel counts as settled once ready has stayed high for a while,
  // by then the receiver has also left its pause states
  task automatic wait_idle();
    int run;
    int spent;
    run   = 0;
    spent = 0;
    while (run < IDLE_STABLE) begin
      @(negedge clk_i);
      spent++;
      run = alert_ready_o ? run + 1 : 0;
      if (run < IDLE_STABLE && spent > IDLE_TIMEOUT) begin
        report_timeout("the channel to settle with alert_ready_o high");
      end
    end
  endtask

  // raises valid, waits for the transfer and checks the cycles after it,
  // with reinit set an init starts right after the alert was reported
  task automatic send_alert(input logic check_lat, input logic reinit);
    int spent;
    int i;
    spent = 0;
    @(posedge clk_i);
    alert_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!alert_ready_o) begin
      spent++;
      if (spent > READY_TIMEOUT) begin
        report_timeout("alert_ready_o on an alert request");
      end
      @(negedge clk_i);
    end
    // valid and ready are both high, the transfer happens on this edge
    @(posedge clk_i);
    alert_valid_i <= 1'b0;
    for (i = 1; i < READY_RETURN; i++) begin
      @(negedge clk_i);
      // ready stays low until the handshake and both pauses are over
      check_pulse("alert_ready_o", 1'b0, alert_ready_o);
      if (check_lat) begin
        check_pulse("alert_o", (i == ALERT_LATENCY), alert_o);
      end
      if (reinit && i == ALERT_LATENCY) begin
        @(posedge clk_i);
        init_trig_i <= 1'b1;
        break;
      end
    end
  endtask

  // each alert first waits a random zero to three idle cycles, so some
  // of them come back to back
  task automatic run_alerts(input int n, input logic check_lat);
    int k;
    for (k = 0; k < n; k++) begin
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[17:16]) @(posedge clk_i);
      send_alert(check_lat, 1'b0);
    end
  endtask

  // the first init comes from reset, later ones interrupt a live handshake
  task automatic run_init(input int hold);
    int k;
    if (!init_trig_i) begin
      send_alert(1'b1, 1'b1);
    end
    for (k = 0; k < hold; k++) begin
      @(negedge clk_i);
      check_pulse("alert_ready_o", 1'b0, alert_ready_o);
    end
    @(posedge clk_i);
    init_trig_i <= 1'b0;
  endtask

  // a ping request with timeout 1 fails after two cycles, so one request
  // takes PING_PERIOD+3 cycles and never fewer than PING_PERIOD+1
  task automatic load_rows();
    rows[0] = '{OpInit, 6, 0, 0, 0, 0};
    rows[1] = '{OpAlert, 4, 4, 0, 0, 0};
    rows[2] = '{OpAlert, 12, 12, 0, 0, 0};
    rows[3] = '{OpPing, 10, 10, 0, 0, 0};
    rows[4] = '{OpTimeout, TIMEOUT_WINDOW, -1, TIMEOUT_WINDOW / int'(PING_PERIOD + 3) - 1,
                TIMEOUT_WINDOW / int'(PING_PERIOD + 1) + 1, 0};
    rows[5] = '{OpInit, 5, 1, 0, 0, 0};
    rows[6] = '{OpAlert, 3, 3, 0, 0, 0};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int r;
    int base_alert;
    int base_fail;
    int base_integ;
    rst_b          = 1'b0;
    alert_valid_i  = 1'b0;
    init_trig_i    = 1'b1;
    ping_en_i      = 1'b0;
    ping_timeout_i = TIMEOUT_W'(GOOD_TIMEOUT);
    lcg_state      = 32'hb2;
    load_rows();
    repeat (3) @(posedge clk_i);
    rst_b <= 1'b1;

    for (r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk_i);
      base_alert = alert_cnt;
      base_fail  = fail_cnt;
      base_integ = integ_cnt;
      case (rows[r].op)
        OpInit: run_init(rows[r].count);
        OpAlert: run_alerts(rows[r].count, 1'b1);
        // pings may take over a handshake, so only the totals are checked
        OpPing: begin
          @(posedge clk_i);
          ping_timeout_i <= TIMEOUT_W'(GOOD_TIMEOUT);
          ping_en_i      <= 1'b1;
          run_alerts(rows[r].count, 1'b0);
          @(posedge clk_i);
          ping_en_i <= 1'b0;
        end
        OpTimeout: begin
          @(posedge clk_i);
          ping_timeout_i <= TIMEOUT_W'(1);
          ping_en_i      <= 1'b1;
          repeat (rows[r].count) @(posedge clk_i);
          ping_en_i <= 1'b0;
        end
        default: report_timeout("a known row kind in the table");
      endcase
      wait_idle();
      if (rows[r].exp_alert >= 0) begin
        check_count("alert_o pulses", rows[r].exp_alert, rows[r].exp_alert,
                    alert_cnt - base_alert);
      end
      check_count("ping_fail_o pulses", rows[r].fail_min, rows[r].fail_max,
                  fail_cnt - base_fail);
      check_count("integ_fail_o pulses", rows[r].exp_integ, rows[r].exp_integ,
                  integ_cnt - base_integ);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* bench/alert_channel_asserts.sv */
`timescale 1ns/1ps

module alert_channel_asserts import alert_pkg::*; (
  input logic      clk_i,
  input logic      rst_b,
  input rx_state_e state_i,
  input logic      ping_pending_i,
  input logic      ping_ok_i,
  input logic      alert_i,
  input logic      ack_p_i,
  input logic      ack_n_i,
  input logic      ping_p_i,
  input logic      ping_n_i
);

  // both init states count as init, the pairs are only forced in the first
  logic in_init;

  assign in_init = (state_i == RxInitReq) || (state_i == RxInitAckWait);

  ////////////////////////////////////////////////////////////////////////////
  // receiver protocol properties
  ////////////////////////////////////////////////////////////////////////////

  // outside init the ping line is always a valid differential pair
  ping_pair_clean: assert property (@(posedge clk_i) disable iff (!rst_b)
    !in_init |-> (ping_p_i != ping_n_i))
    else $error("ping pair not complementary outside init");

  // an answered ping needs an outstanding request
  ping_ok_pending: assert property (@(posedge clk_i) disable iff (!rst_b)
    ping_ok_i |-> ping_pending_i)
    else $error("ping_ok raised without a pending ping");

  // init swallows every handshake, nothing may be reported as an alert
  no_alert_in_init: assert property (@(posedge clk_i) disable iff (!rst_b)
    in_init |-> !alert_i)
    else $error("alert reported while init is in progress");

  // the cycle after init ends the ack pair must already be clean again
  ack_clean_after_init: assert property (@(posedge clk_i) disable iff (!rst_b)
    (($past(state_i) == RxInitAckWait) && (state_i == RxPause0)) |-> (ack_p_i != ack_n_i))
    else $error("ack pair still broken after leaving init");

endmodule

bind alert_receiver alert_channel_asserts i_asserts (
  .clk_i          (clk_i),
  .rst_b          (rst_b),
  .state_i        (state_q),
  .ping_pending_i (ping_pending_q),
  .ping_ok_i      (ping_ok_o),
  .alert_i        (alert_o),
  .ack_p_i        (ack_p_o),
  .ack_n_i        (ack_n_o),
  .ping_p_i       (ping_p_o),
  .ping_n_i       (ping_n_o)
);

/* hdl/alert_channel.sv */
`timescale 1ns/1ps

module alert_channel import alert_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_b,
  input  logic                 alert_valid_i,
  input  logic                 init_trig_i,
  input  logic                 ping_en_i,
  input  logic [TIMEOUT_W-1:0] ping_timeout_i,
  output logic                 alert_ready_o,
  output logic                 alert_o,
  output logic                 integ_fail_o,
  output logic                 ping_fail_o
);

  // differential wires between the two sides
  logic alert_p;
  logic alert_n;
  logic ack_p;
  logic ack_n;
  logic ping_p;
  logic ping_n;

  // decoded levels and flags
  logic alert_level;
  logic alert_sigint;
  logic ack_level;
  logic ack_sigint;
  logic ping_toggle;

  // ping timer to receiver
  logic ping_req;
  logic ping_ok;

  ////////////////////////////////////////////////////////////////////////////
  // sender side
  ////////////////////////////////////////////////////////////////////////////

  alert_diff_decode i_ack_dec (
    .clk_i    (clk_i),
    .rst_b    (rst_b),
    .diff_p_i (ack_p),
    .diff_n_i (ack_n),
    .level_o  (ack_level),
    .toggle_o (),
    .sigint_o (ack_sigint)
  );

  // only the toggle of the ping line matters to the sender
  alert_diff_decode i_ping_dec (
    .clk_i    (clk_i),
    .rst_b    (rst_b),
    .diff_p_i (ping_p),
    .diff_n_i (ping_n),
    .level_o  (),
    .toggle_o (ping_toggle),
    .sigint_o ()
  );

  alert_sender i_sender (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .alert_valid_i (alert_valid_i),
    .alert_ready_o (alert_ready_o),
    .ack_level_i   (ack_level),
    .ack_sigint_i  (ack_sigint),
    .ping_toggle_i (ping_toggle),
    .alert_p_o     (alert_p),
    .alert_n_o     (alert_n)
  );

  ////////////////////////////////////////////////////////////////////////////
  // receiver side
  ////////////////////////////////////////////////////////////////////////////

  alert_diff_decode i_alert_dec (
    .clk_i    (clk_i),
    .rst_b    (rst_b),
    .diff_p_i (alert_p),
    .diff_n_i (alert_n),
    .level_o  (alert_level),
    .toggle_o (),
    .sigint_o (alert_sigint)
  );

  alert_receiver i_receiver (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .init_trig_i    (init_trig_i),
    .ping_req_i     (ping_req),
    .alert_level_i  (alert_level),
    .alert_sigint_i (alert_sigint),
    .ping_ok_o      (ping_ok),
    .integ_fail_o   (integ_fail_o),
    .alert_o        (alert_o),
    .ack_p_o        (ack_p),
    .ack_n_o        (ack_n),
    .ping_p_o       (ping_p),
    .ping_n_o       (ping_n)
  );

  ping_timer i_ping_timer (
    .clk_i          (clk_i),
    .rst_b          (rst_b),
    .enable_i       (ping_en_i),
    .ping_timeout_i (ping_timeout_i),
    .ping_ok_i      (ping_ok),
    .ping_req_o     (ping_req),
    .ping_fail_o    (ping_fail_o)
  );

endmodule

/* hdl/ping_timer.sv */
`timescale 1ns/1ps

module ping_timer import alert_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_b,
  input  logic                 enable_i,
  input  logic [TIMEOUT_W-1:0] ping_timeout_i,
  input  logic                 ping_ok_i,
  output logic                 ping_req_o,
  output logic                 ping_fail_o
);

  // one counter serves both phases, the request flop tells which one
  logic [TIMEOUT_W-1:0] cnt_q;
  logic                 req_q;

  assign ping_req_o  = req_q;
  // a late ping_ok in the same cycle still counts as an answer
  assign ping_fail_o = req_q && !ping_ok_i && (cnt_q == ping_timeout_i);

  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      cnt_q <= '0;
      req_q <= 1'b0;
    end else if (!req_q) begin
      // period phase, counts only while pings are enabled
      if (!enable_i) begin
        cnt_q <= '0;
      end else if (cnt_q == TIMEOUT_W'(PING_PERIOD)) begin
        cnt_q <= '0;
        req_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else begin
      // timeout phase, either answer or timeout ends the request
      if (ping_ok_i || ping_fail_o) begin
        cnt_q <= '0;
        req_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

/* hdl/alert_receiver.sv */
`timescale 1ns/1ps

module alert_receiver import alert_pkg::*; (
  input  logic clk_i,
  input  logic rst_b,
  input  logic init_trig_i,
  input  logic ping_req_i,
  input  logic alert_level_i,
  input  logic alert_sigint_i,
  output logic ping_ok_o,
  output logic integ_fail_o,
  output logic alert_o,
  output logic ack_p_o,
  output logic ack_n_o,
  output logic ping_p_o,
  output logic ping_n_o
);

  rx_state_e state_d;
  rx_state_e state_q;
  logic      ping_req_q;
  logic      ping_rise;
  logic      ping_pending_d;
  logic      ping_pending_q;
  logic      send_init;
  logic      send_ping;
  logic      ack_pd;
  logic      ack_nd;
  logic      ack_pq;
  logic      ack_nq;
  logic      ping_pd;
  logic      ping_nd;
  logic      ping_pq;
  logic      ping_nq;

  // a ping is requested by the rising edge of ping_req_i only, a request
  // tied high must not turn every native alert into a ping answer
  assign ping_rise      = ping_req_i && !ping_req_q;
  assign ping_pending_d = ping_rise | (!ping_ok_o && ping_req_i && ping_pending_q);

  // ping goes out as a level toggle, init forces both pairs to 0/0
  assign ping_pd = send_init ? 1'b0 : (send_ping ? ~ping_pq : ping_pq);
  assign ping_nd = send_init ? 1'b0 : ~ping_pd;
  assign ack_nd  = send_init ? ack_pd : ~ack_pd;

  ////////////////////////////////////////////////////////////////////////////
  // protocol FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    ack_pd       = 1'b0;
    ping_ok_o    = 1'b0;
    integ_fail_o = 1'b0;
    alert_o      = 1'b0;
    send_init    = 1'b0;
    send_ping    = ping_rise;

    unique case (state_q)
      // a rising alert level starts a handshake, the pending bit decides
      // whether it answers a ping or reports a native alert
      RxIdle: begin
        if (alert_level_i) begin
          state_d = RxHsAckWait;
          ack_pd  = 1'b1;
          if (ping_pending_q) begin
            ping_ok_o = 1'b1;
          end else begin
            alert_o = 1'b1;
          end
        end
      end
      RxHsAckWait: begin
        if (!alert_level_i) begin
          state_d = RxPause0;
        end else begin
          ack_pd = 1'b1;
        end
      end
      RxPause0: state_d = RxPause1;
      RxPause1: state_d = RxIdle;
      // pings are answered here directly while init is held, afterwards
      // the mirrored sigint from the sender acts as the acknowledgement
      RxInitReq: begin
        send_init = 1'b1;
        send_ping = 1'b0;
        if (init_trig_i) begin
          ping_ok_o = ping_pending_q;
        end else if (alert_sigint_i) begin
          state_d = RxInitAckWait;
        end
      end
      // pairs are clean again, wait for the sender to clean up its side
      RxInitAckWait: begin
        send_ping = 1'b0;
        if (!alert_sigint_i) begin
          state_d   = RxPause0;
          // a ping that came in after init was released is forwarded now
          send_ping = ping_rise || ping_pending_q;
        end
      end
      default: state_d = RxIdle;
    endcase

    // outside init, an init request overrides everything and a broken
    // alert pair clamps all outputs and flags the failure
    if (!(state_q inside {RxInitReq, RxInitAckWait})) begin
      if (init_trig_i) begin
        state_d   = RxInitReq;
        ack_pd    = 1'b0;
        ping_ok_o = 1'b0;
        alert_o   = 1'b0;
        send_init = 1'b1;
      end else if (alert_sigint_i) begin
        state_d      = RxIdle;
        ack_pd       = 1'b0;
        ping_ok_o    = 1'b0;
        alert_o      = 1'b0;
        integ_fail_o = 1'b1;
      end
    end
  end

  // both pairs reset into the init pattern to match the reset state
  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      state_q        <= RxInitReq;
      ping_req_q     <= 1'b0;
      ping_pending_q <= 1'b0;
      ack_pq         <= 1'b0;
      ack_nq         <= 1'b0;
      ping_pq        <= 1'b0;
      ping_nq        <= 1'b0;
    end else begin
      state_q        <= state_d;
      ping_req_q     <= ping_req_i;
      ping_pending_q <= ping_pending_d;
      ack_pq         <= ack_pd;
      ack_nq         <= ack_nd;
      ping_pq        <= ping_pd;
      ping_nq        <= ping_nd;
    end
  end

  assign ack_p_o  = ack_pq;
  assign ack_n_o  = ack_nq;
  assign ping_p_o = ping_pq;
  assign ping_n_o = ping_nq;

endmodule

/* hdl/alert_sender.sv */
`timescale 1ns/1ps

module alert_sender import alert_pkg::*; (
  input  logic clk_i,
  input  logic rst_b,
  input  logic alert_valid_i,
  output logic alert_ready_o,
  input  logic ack_level_i,
  input  logic ack_sigint_i,
  input  logic ping_toggle_i,
  output logic alert_p_o,
  output logic alert_n_o
);

  tx_state_e state_d;
  tx_state_e state_q;
  logic      ping_pend_d;
  logic      ping_pend_q;
  logic      alert_pd;
  logic      alert_nd;
  logic      alert_pq;
  logic      alert_nq;

  // a native alert is only taken when nothing else needs the pair,
  // a pending or just arriving ping wins and init blocks everything
  assign alert_ready_o = (state_q == TxIdle) && !ping_pend_q && !ping_toggle_i &&
                         !ack_sigint_i;

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // the alert pair is computed from the current state and registered, so
  // the wire rises one cycle after the FSM enters a handshake state
  always_comb begin
    state_d     = state_q;
    alert_pd    = 1'b0;
    // every toggle on the ping line asks for one answer
    ping_pend_d = ping_pend_q | ping_toggle_i;

    unique case (state_q)
      TxIdle: begin
        if (ping_pend_q) begin
          // pings are served first, a new toggle in this cycle stays pending
          state_d     = TxPingHs;
          ping_pend_d = ping_toggle_i;
        end else if (alert_valid_i && alert_ready_o) begin
          state_d = TxAlertHs;
        end
      end
      // hold the alert high until the receiver acknowledges it
      TxAlertHs, TxPingHs: begin
        if (ack_level_i) begin
          state_d = TxPause0;
        end else begin
          alert_pd = 1'b1;
        end
      end
      TxPause0: state_d = TxPause1;
      // the receiver drops ack only after it has seen alert low
      TxPause1: begin
        if (!ack_level_i) begin
          state_d = TxIdle;
        end
      end
      default: state_d = TxIdle;
    endcase

    alert_nd = ~alert_pd;

    // a broken ack pair is the receiver asking for init, we answer by
    // breaking the alert pair too and drop whatever was in flight
    if (ack_sigint_i) begin
      state_d     = TxIdle;
      alert_pd    = 1'b0;
      alert_nd    = 1'b0;
      ping_pend_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      state_q     <= TxIdle;
      ping_pend_q <= 1'b0;
      alert_pq    <= 1'b0;
      alert_nq    <= 1'b1;
    end else begin
      state_q     <= state_d;
      ping_pend_q <= ping_pend_d;
      alert_pq    <= alert_pd;
      alert_nq    <= alert_nd;
    end
  end

  assign alert_p_o = alert_pq;
  assign alert_n_o = alert_nq;

endmodule

/* hdl/alert_diff_decode.sv */
`timescale 1ns/1ps

module alert_diff_decode (
  input  logic clk_i,
  input  logic rst_b,
  input  logic diff_p_i,
  input  logic diff_n_i,
  output logic level_o,
  output logic toggle_o,
  output logic sigint_o
);

  // last good level seen on the pair
  logic level_q;
  // pair was broken in the previous cycle
  logic sigint_q;

  // a healthy pair is always complementary, equal wires mean a broken pair
  // or an init request from the far side
  assign sigint_o = (diff_p_i == diff_n_i);

  // while the pair is broken we keep reporting the last good level
  assign level_o = sigint_o ? level_q : diff_p_i;

  // a toggle needs two clean samples in a row, so the first clean level
  // after an init sequence is taken as the new reference and does not
  // count as a ping
  assign toggle_o = !sigint_o && !sigint_q && (diff_p_i != level_q);

  always_ff @(posedge clk_i) begin
    if (!rst_b) begin
      level_q  <= 1'b0;
      // start out as if the pair had just been broken
      sigint_q <= 1'b1;
    end else begin
      level_q  <= level_o;
      sigint_q <= sigint_o;
    end
  end

endmodule

/* hdl/alert_pkg.sv */
package alert_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // protocol state machines
  ////////////////////////////////////////////////////////////////////////////

  // receiver states, reset enters RxInitReq so that every reset doubles
  // as an in-band init of the whole channel
  typedef enum logic [2:0] {
    RxIdle,
    RxHsAckWait,
    RxPause0,
    RxPause1,
    RxInitReq,
    RxInitAckWait
  } rx_state_e;

  // sender states, alert and ping answers share the same four-phase handshake
  typedef enum logic [2:0] {
    TxIdle,
    TxAlertHs,
    TxPingHs,
    TxPause0,
    TxPause1
  } tx_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////////////////////

  // idle cycles of the ping timer between two ping requests
  localparam int unsigned PING_PERIOD = 16;
  // width of the runtime ping timeout and of the timer counter
  localparam int unsigned TIMEOUT_W = 8;
  // both sides rest this many cycles after each handshake
  localparam int unsigned PAUSE_CYCLES = 2;

endpackage
